//--- list.f
decode_pkg.sv
decode_stage_if.sv
inst_capture.sv
imm_generator.sv
control_decoder.sv
register_file.sv
decode_stage.sv
decode_tb.sv

//--- decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    localparam int reset_cycles = 16;
    localparam int issued_count = 3 + 30 + 17 + 2 + 2; // Instructions over all tests.

    logic                                  clock;
    logic                                  reset;
    logic                                  valid_last;
    logic                                  ready_last;
    logic [decode_pkg::xlen-1:0]           inst;
    logic [decode_pkg::xlen-1:0]           pc;
    logic                                  inst_clear;
    logic                                  reg_wen;
    logic [decode_pkg::reg_addr_width-1:0] rd;
    logic [decode_pkg::xlen-1:0]           rd_value;
    logic                                  valid_next;
    logic                                  ready_next;
    logic [decode_pkg::xlen-1:0]           pc_next;
    logic [decode_pkg::xlen-1:0]           rs1_value;
    logic [decode_pkg::xlen-1:0]           rs2_value;
    logic [decode_pkg::xlen-1:0]           imm;
    decode_pkg::alu_op_t                   alu_op;
    decode_pkg::src_a_t                    src_a_sel;
    decode_pkg::src_b_t                    src_b_sel;
    logic                                  mem_wen;
    logic                                  mem_ren;
    logic                                  reg_wen_next;
    logic                                  branch;
    logic                                  branch_invert;
    logic                                  jump;
    logic [decode_pkg::reg_addr_width-1:0] rd_next;
    logic [2:0]                            funct3;

    logic [31:0] seed = 32'd76;
    logic [31:0] model_regs [0:31]; // Expected register file contents.
    int          error_count = 0;

    decode_stage dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ========================================
    // Stimulus helpers and reference model
    // ========================================
    function logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd_f,
        input logic [6:0] op);
        decode_pkg::inst_word_t w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd_f;
        w.r_fmt.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] i12, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd_f, input logic [6:0] op);
        return {i12, rs1, f3, rd_f, op};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] i12, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {i12[11:5], rs2, rs1, f3, i12[4:0], decode_pkg::op_store};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] i13, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {i13[12], i13[10:5], rs2, rs1, f3, i13[4:1], i13[11], decode_pkg::op_branch};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] i21, input logic [4:0] rd_f);
        return {i21[20], i21[10:1], i21[11], i21[19:12], rd_f, decode_pkg::op_jal};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Presents one instruction and returns at the falling edge after acceptance.
    task automatic send_inst(input logic [31:0] word, input logic [31:0] addr);
        @(posedge clock);
        valid_last <= 1'b1;
        inst       <= word;
        pc         <= addr;
        @(negedge clock);
        while (!ready_last) begin
            @(negedge clock);
        end
        @(posedge clock); // Accepted here.
        valid_last <= 1'b0;
        @(negedge clock);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] value);
        @(posedge clock);
        reg_wen  <= 1'b1;
        rd       <= addr;
        rd_value <= value;
        @(posedge clock);
        reg_wen <= 1'b0;
        if (addr != 5'd0) begin
            model_regs[addr] = value;
        end
    endtask

    task automatic check_controls(
        input string               name,
        input logic [31:0]         word,
        input decode_pkg::alu_op_t exp_alu,
        input decode_pkg::src_a_t  exp_a,
        input decode_pkg::src_b_t  exp_b,
        input logic [5:0]          exp_flags // mem_wen, mem_ren, branch, invert, jump, reg_wen.
    );
        send_inst(word, 32'h400);
        compare_value({name, " valid_next"}, 1, valid_next);
        compare_value({name, " alu_op"}, exp_alu, alu_op);
        compare_value({name, " src_a_sel"}, exp_a, src_a_sel);
        compare_value({name, " src_b_sel"}, exp_b, src_b_sel);
        compare_value({name, " mem_wen"}, exp_flags[5], mem_wen);
        compare_value({name, " mem_ren"}, exp_flags[4], mem_ren);
        compare_value({name, " branch"}, exp_flags[3], branch);
        compare_value({name, " branch_invert"}, exp_flags[2], branch_invert);
        compare_value({name, " jump"}, exp_flags[1], jump);
        compare_value({name, " reg_wen_next"}, exp_flags[0], reg_wen_next);
        compare_value({name, " funct3"}, word[14:12], funct3);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_register_file();
        write_reg(5'd3, next_rand());
        write_reg(5'd7, next_rand());
        write_reg(5'd12, next_rand());
        write_reg(5'd29, next_rand());
        write_reg(5'd0, next_rand()); // Must be dropped.
        send_inst(encode_r(7'h00, 5'd7, 5'd3, 3'b000, 5'd9, decode_pkg::op_r), 32'h10);
        compare_value("add valid_next", 1, valid_next);
        compare_value("add rs1_value", model_regs[3], rs1_value);
        compare_value("add rs2_value", model_regs[7], rs2_value);
        compare_value("add rd_next", 9, rd_next);
        compare_value("add alu_op", decode_pkg::alu_add, alu_op);
        compare_value("add reg_wen_next", 1, reg_wen_next);
        send_inst(encode_r(7'h20, 5'd29, 5'd12, 3'b000, 5'd30, decode_pkg::op_r), 32'h14);
        compare_value("sub rs1_value", model_regs[12], rs1_value);
        compare_value("sub rs2_value", model_regs[29], rs2_value);
        compare_value("sub rd_next", 30, rd_next);
        compare_value("sub alu_op", decode_pkg::alu_sub, alu_op);
        send_inst(encode_r(7'h00, 5'd0, 5'd29, 3'b000, 5'd1, decode_pkg::op_r), 32'h18);
        compare_value("x0 rs2_value", 0, rs2_value);
        compare_value("x0 rs1_value", model_regs[29], rs1_value);
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [11:0] i12;
        logic [4:0]  shamt;
        logic [12:0] i13;
        logic [20:0] i21;
        for (int round = 0; round < 3; round++) begin
            r     = next_rand();
            i12   = r[31:20];
            shamt = r[19:15];
            i13   = {r[31:20], 1'b0};
            i21   = {r[31:12], 1'b0};
            send_inst(encode_i(i12, 5'd1, 3'b000, 5'd2, decode_pkg::op_imm), 32'h100);
            compare_value("addi imm", {{20{i12[11]}}, i12}, imm);
            send_inst(encode_i({7'h00, shamt}, 5'd1, 3'b001, 5'd2, decode_pkg::op_imm), 32'h104);
            compare_value("slli imm", {27'd0, shamt}, imm);
            send_inst(encode_i({7'h20, shamt}, 5'd1, 3'b101, 5'd2, decode_pkg::op_imm), 32'h108);
            compare_value("srai imm", {27'd0, shamt}, imm);
            send_inst(encode_i(i12, 5'd1, 3'b010, 5'd2, decode_pkg::op_load), 32'h10c);
            compare_value("lw imm", {{20{i12[11]}}, i12}, imm);
            send_inst(encode_s(i12, 5'd2, 5'd1, 3'b010), 32'h110);
            compare_value("sw imm", {{20{i12[11]}}, i12}, imm);
            send_inst(encode_b(i13, 5'd2, 5'd1, 3'b000), 32'h114);
            compare_value("beq imm", {{19{i13[12]}}, i13}, imm);
            send_inst({r[31:12], 5'd2, decode_pkg::op_lui}, 32'h118);
            compare_value("lui imm", {r[31:12], 12'd0}, imm);
            send_inst({r[31:12], 5'd2, decode_pkg::op_auipc}, 32'h11c);
            compare_value("auipc imm", {r[31:12], 12'd0}, imm);
            send_inst(encode_j(i21, 5'd1), 32'h120);
            compare_value("jal imm", {{11{i21[20]}}, i21}, imm);
            send_inst(encode_i(i12, 5'd1, 3'b000, 5'd1, decode_pkg::op_jalr), 32'h124);
            compare_value("jalr imm", {{20{i12[11]}}, i12}, imm);
        end
    endtask

    task automatic test_controls();
        check_controls("add", encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, decode_pkg::op_r),
            decode_pkg::alu_add, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b000001);
        check_controls("sub", encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, decode_pkg::op_r),
            decode_pkg::alu_sub, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b000001);
        check_controls("sra", encode_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, decode_pkg::op_r),
            decode_pkg::alu_sra, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b000001);
        // Bit 10 of the immediate sits where funct7 bit 5 would be.
        check_controls("addi", encode_i(12'h400, 5'd1, 3'b000, 5'd3, decode_pkg::op_imm),
            decode_pkg::alu_add, decode_pkg::src_a_reg, decode_pkg::src_b_imm, 6'b000001);
        check_controls("srai", encode_i(12'h403, 5'd1, 3'b101, 5'd3, decode_pkg::op_imm),
            decode_pkg::alu_sra, decode_pkg::src_a_reg, decode_pkg::src_b_imm, 6'b000001);
        check_controls("lw", encode_i(12'h010, 5'd1, 3'b010, 5'd3, decode_pkg::op_load),
            decode_pkg::alu_add, decode_pkg::src_a_reg, decode_pkg::src_b_imm, 6'b010001);
        check_controls("sw", encode_s(12'h010, 5'd2, 5'd1, 3'b010),
            decode_pkg::alu_add, decode_pkg::src_a_reg, decode_pkg::src_b_imm, 6'b100000);
        check_controls("beq", encode_b(13'h20, 5'd2, 5'd1, 3'b000),
            decode_pkg::alu_eq, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001000);
        check_controls("bne", encode_b(13'h20, 5'd2, 5'd1, 3'b001),
            decode_pkg::alu_eq, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001100);
        check_controls("blt", encode_b(13'h20, 5'd2, 5'd1, 3'b100),
            decode_pkg::alu_slt, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001000);
        check_controls("bge", encode_b(13'h20, 5'd2, 5'd1, 3'b101),
            decode_pkg::alu_slt, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001100);
        check_controls("bltu", encode_b(13'h20, 5'd2, 5'd1, 3'b110),
            decode_pkg::alu_sltu, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001000);
        check_controls("bgeu", encode_b(13'h20, 5'd2, 5'd1, 3'b111),
            decode_pkg::alu_sltu, decode_pkg::src_a_reg, decode_pkg::src_b_reg, 6'b001100);
        check_controls("jal", encode_j(21'h100, 5'd1),
            decode_pkg::alu_add, decode_pkg::src_a_pc, decode_pkg::src_b_imm, 6'b000011);
        check_controls("jalr", encode_i(12'h008, 5'd1, 3'b000, 5'd1, decode_pkg::op_jalr),
            decode_pkg::alu_add, decode_pkg::src_a_reg, decode_pkg::src_b_imm, 6'b000011);
        check_controls("lui", {20'h12345, 5'd3, decode_pkg::op_lui},
            decode_pkg::alu_add, decode_pkg::src_a_zero, decode_pkg::src_b_imm, 6'b000001);
        check_controls("auipc", {20'h12345, 5'd3, decode_pkg::op_auipc},
            decode_pkg::alu_add, decode_pkg::src_a_pc, decode_pkg::src_b_imm, 6'b000001);
    endtask

    task automatic test_flush();
        @(posedge clock);
        inst_clear <= 1'b1; // Input is idle here.
        @(posedge clock);
        inst_clear <= 1'b0;
        send_inst(encode_r(7'h00, 5'd7, 5'd3, 3'b000, 5'd4, decode_pkg::op_r), 32'h200);
        compare_value("flush bubble valid_next", 0, valid_next);
        send_inst(encode_r(7'h00, 5'd7, 5'd3, 3'b000, 5'd6, decode_pkg::op_r), 32'h204);
        compare_value("flush second valid_next", 1, valid_next);
        compare_value("flush second pc_next", 32'h204, pc_next);
        compare_value("flush second rd_next", 6, rd_next);
        compare_value("flush second rs1_value", model_regs[3], rs1_value);
    endtask

    task automatic test_back_pressure();
        @(posedge clock);
        ready_next <= 1'b0;
        send_inst(encode_i(12'h123, 5'd3, 3'b000, 5'd8, decode_pkg::op_imm), 32'h300);
        @(posedge clock);
        valid_last <= 1'b1; // Second item waits at the input.
        inst       <= encode_r(7'h20, 5'd29, 5'd12, 3'b000, 5'd10, decode_pkg::op_r);
        pc         <= 32'h304;
        repeat (5) begin
            @(negedge clock);
            compare_value("hold valid_next", 1, valid_next);
            compare_value("hold ready_last", 0, ready_last);
            compare_value("hold pc_next", 32'h300, pc_next);
            compare_value("hold rd_next", 8, rd_next);
            compare_value("hold imm", 32'h123, imm);
            compare_value("hold rs1_value", model_regs[3], rs1_value);
        end
        @(posedge clock);
        ready_next <= 1'b1;
        @(negedge clock);
        compare_value("release ready_last", 1, ready_last);
        @(posedge clock); // First leaves, second is taken.
        valid_last <= 1'b0;
        @(negedge clock);
        compare_value("second valid_next", 1, valid_next);
        compare_value("second pc_next", 32'h304, pc_next);
        compare_value("second rd_next", 10, rd_next);
        compare_value("second alu_op", decode_pkg::alu_sub, alu_op);
        @(negedge clock);
        compare_value("drained valid_next", 0, valid_next);
    endtask

    initial begin
        repeat (reset_cycles + 40 * issued_count) @(posedge clock);
        $display("Watchdog expired, the DUT stopped responding and the run hung.");
        $display("Finished with errors");
        $fatal(1, "Timeout.");
    end

    initial begin
        reset      <= 1'b1;
        valid_last <= 1'b0;
        inst       <= '0;
        pc         <= '0;
        inst_clear <= 1'b0;
        reg_wen    <= 1'b0;
        rd         <= '0;
        rd_value   <= '0;
        ready_next <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_value("reset valid_next", 0, valid_next);
        compare_value("reset ready_last", 1, ready_last);
        test_register_file();
        test_immediates();
        test_controls();
        test_flush();
        test_back_pressure();
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                  clock,
    input  logic                                  reset,
    // ========================================
    // Fetch side
    // ========================================
    input  logic                                  valid_last,
    output logic                                  ready_last,
    input  logic [decode_pkg::xlen-1:0]           inst,
    input  logic [decode_pkg::xlen-1:0]           pc,
    input  logic                                  inst_clear,
    // ========================================
    // Write-back side
    // ========================================
    input  logic                                  reg_wen,
    input  logic [decode_pkg::reg_addr_width-1:0] rd,
    input  logic [decode_pkg::xlen-1:0]           rd_value,
    // ========================================
    // Execute side
    // ========================================
    output logic                                  valid_next,
    input  logic                                  ready_next,
    output logic [decode_pkg::xlen-1:0]           pc_next,
    output logic [decode_pkg::xlen-1:0]           rs1_value,
    output logic [decode_pkg::xlen-1:0]           rs2_value,
    output logic [decode_pkg::xlen-1:0]           imm,
    output decode_pkg::alu_op_t                   alu_op,
    output decode_pkg::src_a_t                    src_a_sel,
    output decode_pkg::src_b_t                    src_b_sel,
    output logic                                  mem_wen,
    output logic                                  mem_ren,
    output logic                                  reg_wen_next,
    output logic                                  branch,
    output logic                                  branch_invert,
    output logic                                  jump,
    output logic [decode_pkg::reg_addr_width-1:0] rd_next,
    output logic [2:0]                            funct3
);

    decode_stage_if stage ();

    assign stage.advance = stage.valid && ready_next;
    assign valid_next    = stage.valid;
    assign pc_next       = stage.pc;
    assign funct3        = stage.inst.r_fmt.funct3;

    inst_capture capture_i (
        .clock      (clock),
        .reset      (reset),
        .valid_last (valid_last),
        .ready_last (ready_last),
        .inst       (inst),
        .pc         (pc),
        .inst_clear (inst_clear),
        .stage      (stage.source)
    );

    imm_generator imm_i (
        .stage (stage.sink),
        .imm   (imm)
    );

    control_decoder control_i (
        .stage         (stage.sink),
        .alu_op        (alu_op),
        .src_a_sel     (src_a_sel),
        .src_b_sel     (src_b_sel),
        .mem_wen       (mem_wen),
        .mem_ren       (mem_ren),
        .reg_wen_next  (reg_wen_next),
        .branch        (branch),
        .branch_invert (branch_invert),
        .jump          (jump),
        .rd_next       (rd_next)
    );

    register_file regs_i (
        .clock  (clock),
        .reset  (reset),
        .wen    (reg_wen),
        .waddr  (rd),
        .raddr1 (stage.inst.r_fmt.rs1),
        .raddr2 (stage.inst.r_fmt.rs2),
        .wdata  (rd_value),
        .rdata1 (rs1_value),
        .rdata2 (rs2_value)
    );

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  wen,
    input  logic [decode_pkg::reg_addr_width-1:0] waddr,
    input  logic [decode_pkg::reg_addr_width-1:0] raddr1,
    input  logic [decode_pkg::reg_addr_width-1:0] raddr2,
    input  logic [decode_pkg::xlen-1:0]           wdata,
    output logic [decode_pkg::xlen-1:0]           rdata1,
    output logic [decode_pkg::xlen-1:0]           rdata2
);

    // Register 0 has no storage.
    logic [decode_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // No bypass from the write port.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    decode_stage_if.sink                          stage,
    output decode_pkg::alu_op_t                   alu_op,
    output decode_pkg::src_a_t                    src_a_sel,
    output decode_pkg::src_b_t                    src_b_sel,
    output logic                                  mem_wen,
    output logic                                  mem_ren,
    output logic                                  reg_wen_next,
    output logic                                  branch,
    output logic                                  branch_invert,
    output logic                                  jump,
    output logic [decode_pkg::reg_addr_width-1:0] rd_next
);

    decode_pkg::inst_word_t word;

    // ALU op for register and immediate arithmetic.
    function automatic decode_pkg::alu_op_t arith_op(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       allow_sub
    );
        case (funct3)
            decode_pkg::f3_add_sub: begin
                arith_op = (alt && allow_sub) ? decode_pkg::alu_sub : decode_pkg::alu_add;
            end
            decode_pkg::f3_sll:     arith_op = decode_pkg::alu_sll;
            decode_pkg::f3_slt:     arith_op = decode_pkg::alu_slt;
            decode_pkg::f3_sltu:    arith_op = decode_pkg::alu_sltu;
            decode_pkg::f3_xor:     arith_op = decode_pkg::alu_xor;
            decode_pkg::f3_srl_sra: begin
                arith_op = alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            end
            decode_pkg::f3_or:      arith_op = decode_pkg::alu_or;
            default:                arith_op = decode_pkg::alu_and;
        endcase
    endfunction

    assign word    = stage.inst;
    assign rd_next = word.r_fmt.rd;

    always_comb begin
        alu_op        = decode_pkg::alu_add;
        src_a_sel     = decode_pkg::src_a_reg;
        src_b_sel     = decode_pkg::src_b_imm;
        mem_wen       = 1'b0;
        mem_ren       = 1'b0;
        reg_wen_next  = 1'b1;
        branch        = 1'b0;
        branch_invert = 1'b0;
        jump          = 1'b0;

        case (word.r_fmt.opcode)
            decode_pkg::op_r: begin
                src_b_sel = decode_pkg::src_b_reg;
                alu_op    = arith_op(word.r_fmt.funct3, word.r_fmt.funct7[5], 1'b1);
            end
            decode_pkg::op_imm: begin
                alu_op = arith_op(word.r_fmt.funct3, word.r_fmt.funct7[5], 1'b0);
            end
            decode_pkg::op_load: begin
                mem_ren = 1'b1;
            end
            decode_pkg::op_store: begin
                mem_wen      = 1'b1;
                reg_wen_next = 1'b0;
            end
            decode_pkg::op_branch: begin
                src_b_sel    = decode_pkg::src_b_reg;
                branch       = 1'b1;
                reg_wen_next = 1'b0;
                case (word.b_fmt.funct3)
                    decode_pkg::f3_beq:  alu_op = decode_pkg::alu_eq;
                    decode_pkg::f3_bne:  alu_op = decode_pkg::alu_eq;
                    decode_pkg::f3_blt:  alu_op = decode_pkg::alu_slt;
                    decode_pkg::f3_bge:  alu_op = decode_pkg::alu_slt;
                    decode_pkg::f3_bltu: alu_op = decode_pkg::alu_sltu;
                    decode_pkg::f3_bgeu: alu_op = decode_pkg::alu_sltu;
                    default:             alu_op = decode_pkg::alu_add;
                endcase
                // Taken on the false compare.
                branch_invert = (word.b_fmt.funct3 == decode_pkg::f3_bne) ||
                                (word.b_fmt.funct3 == decode_pkg::f3_bge) ||
                                (word.b_fmt.funct3 == decode_pkg::f3_bgeu);
            end
            decode_pkg::op_jal: begin
                src_a_sel = decode_pkg::src_a_pc;
                jump      = 1'b1;
            end
            decode_pkg::op_jalr: begin
                jump = 1'b1;
            end
            decode_pkg::op_lui: begin
                src_a_sel = decode_pkg::src_a_zero;
            end
            decode_pkg::op_auipc: begin
                src_a_sel = decode_pkg::src_a_pc;
            end
            default: begin
                reg_wen_next = 1'b0; // Unknown opcode writes nothing.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- imm_generator.sv
`timescale 1ns/1ps
`default_nettype none

module imm_generator (
    decode_stage_if.sink                stage,
    output logic [decode_pkg::xlen-1:0] imm
);

    decode_pkg::inst_word_t word;

    assign word = stage.inst;

    always_comb begin
        case (word.r_fmt.opcode)
            decode_pkg::op_load,
            decode_pkg::op_jalr: begin
                imm = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            end
            decode_pkg::op_imm: begin
                if (word.i_fmt.funct3 == decode_pkg::f3_sll ||
                    word.i_fmt.funct3 == decode_pkg::f3_srl_sra) begin
                    imm = {27'd0, word.r_fmt.rs2}; // Shift amount.
                end else begin
                    imm = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
                end
            end
            decode_pkg::op_store: begin
                imm = {{20{word.s_fmt.imm_11_5[6]}}, word.s_fmt.imm_11_5,
                       word.s_fmt.imm_4_0};
            end
            decode_pkg::op_branch: begin
                imm = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                       word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
            end
            decode_pkg::op_lui,
            decode_pkg::op_auipc: begin
                imm = {word.u_fmt.imm_31_12, 12'd0};
            end
            decode_pkg::op_jal: begin
                imm = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                       word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- inst_capture.sv
`timescale 1ns/1ps
`default_nettype none

module inst_capture (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        valid_last,
    output logic                        ready_last,
    input  logic [decode_pkg::xlen-1:0] inst,
    input  logic [decode_pkg::xlen-1:0] pc,
    input  logic                        inst_clear,
    decode_stage_if.source              stage
);

    logic fire;
    logic flush_pending;
    logic kill;

    // Free when empty or when the held item leaves this cycle.
    assign ready_last = !stage.valid || stage.advance;
    assign fire       = valid_last && ready_last;
    assign kill       = inst_clear || flush_pending;

    // Remembers a flush seen while no instruction was accepted.
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_pending <= 1'b0;
        end else if (fire) begin
            flush_pending <= 1'b0;
        end else if (inst_clear) begin
            flush_pending <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage.valid <= 1'b0;
        end else if (fire) begin
            stage.valid <= !kill; // A flushed item becomes a bubble.
        end else if (stage.advance) begin
            stage.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            stage.inst <= inst;
            stage.pc   <= pc;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_stage_if;

    logic                        valid;   // Output register holds a live item.
    decode_pkg::inst_word_t      inst;
    logic [decode_pkg::xlen-1:0] pc;
    logic                        advance; // Execute takes the held item.

    modport source (
        output valid,
        output inst,
        output pc,
        input  advance
    );

    modport sink (
        input valid,
        input inst,
        input pc
    );

endinterface

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    // ========================================
    // Widths and opcodes
    // ========================================
    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // Arithmetic funct3 codes.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3 codes.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // ========================================
    // Select and ALU codes
    // ========================================
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_eq   = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_reg  = 2'd0,
        src_a_pc   = 2'd1,
        src_a_zero = 2'd2
    } src_a_t;

    typedef enum logic [0:0] {
        src_b_reg = 1'b0,
        src_b_imm = 1'b1
    } src_b_t;

    // ========================================
    // Instruction formats
    // ========================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_t;

endpackage

`default_nettype wire
